/* design/scaler_consts.svh */
// Scaler control constants
`ifndef SCALER_CONSTS_SVH
`define SCALER_CONSTS_SVH

// Pixel and line count width
`define SCALER_DIM_W 12

// Aspect value width, top bit flags an absolute size
`define SCALER_AR_W 13

// HPS user I/O word width
`define SCALER_IO_W 16

// Output mode after reset
`define SCALER_DEF_WIDTH 12'd1920
`define SCALER_DEF_HEIGHT 12'd1080

// Command opcodes
`define SCALER_OP_VIDEO_MODE 8'h20
`define SCALER_OP_VSET 8'h27
`define SCALER_OP_HSET 8'h37
`define SCALER_OP_AR_CUSTOM 8'h3A
`define SCALER_OP_STATUS 8'h40

`endif

/* design/video_pkg.sv */
// Video geometry types
`include "scaler_consts.svh"

package video_pkg;

	typedef logic [`SCALER_DIM_W-1:0] dim_t;
	typedef logic [`SCALER_AR_W-1:0] ar_val_t;

	typedef struct packed {
		dim_t width;
		dim_t height;
	} frame_size_t;

	// Forced output size and scaling flags
	typedef struct packed {
		dim_t vset;
		dim_t hset;
		logic free_scale;
		logic pix_rep;
	} scale_ctrl_t;

	typedef struct packed {
		ar_val_t x;
		ar_val_t y;
	} ar_pair_t;

	typedef struct packed {
		ar_pair_t custom1;
		ar_pair_t custom2;
	} ar_custom_t;

	// Ratio after custom selection, arxy set means absolute size
	typedef struct packed {
		logic arxy;
		dim_t arx;
		dim_t ary;
	} ar_resolved_t;

	typedef struct packed {
		dim_t hmin;
		dim_t hmax;
		dim_t vmin;
		dim_t vmax;
	} window_t;

endpackage

/* design/hps_cmd_pkg.sv */
// HPS command types
`include "scaler_consts.svh"

package hps_cmd_pkg;

	// Opcodes carried by the first strobe of a command
	typedef enum logic [7:0] {
		OP_VIDEO_MODE = `SCALER_OP_VIDEO_MODE,
		OP_VSET       = `SCALER_OP_VSET,
		OP_HSET       = `SCALER_OP_HSET,
		OP_AR_CUSTOM  = `SCALER_OP_AR_CUSTOM,
		OP_STATUS     = `SCALER_OP_STATUS
	} cmd_op_e;

	// Waiting for opcode, or collecting argument words
	typedef enum logic {
		CMD_IDLE,
		CMD_ARGS
	} cmd_state_e;

endpackage

/* design/umuldiv.sv */
// Sequential multiply-divide unit
module umuldiv #(
	parameter int WIDTH = 12
) (
	input  logic             clk_sys,
	input  logic             rst_n_i,
	input  logic             start_i,
	input  logic [WIDTH-1:0] mul1_i,
	input  logic [WIDTH-1:0] mul2_i,
	input  logic [WIDTH-1:0] div_i,
	output logic             busy_o,
	output logic [WIDTH-1:0] result_o
);
	localparam int STEP_W = $clog2(WIDTH + 1);
	localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(WIDTH - 1);

	typedef enum logic [1:0] {
		MD_IDLE,
		MD_MUL,
		MD_DIV,
		MD_DONE
	} md_state_e;

	md_state_e state;
	logic [STEP_W-1:0] step;
	logic [2*WIDTH-1:0] acc;
	logic [2*WIDTH-1:0] mcand;
	logic [WIDTH-1:0] mplier;
	logic [WIDTH-1:0] divisor;
	logic [WIDTH-1:0] rem;
	logic [WIDTH:0] rem_a;
	logic [WIDTH:0] rem_b;
	logic [WIDTH-1:0] rem_1;
	logic [WIDTH-1:0] rem_2;
	logic q_1;
	logic q_2;

	assign busy_o = (state != MD_IDLE);

	// Two restoring steps per clock, product bits enter from the top of acc
	always_comb begin
		rem_a = {rem, acc[2*WIDTH-1]};
		q_1 = (rem_a >= {1'b0, divisor});
		rem_1 = q_1 ? (rem_a[WIDTH-1:0] - divisor) : rem_a[WIDTH-1:0];
		rem_b = {rem_1, acc[2*WIDTH-2]};
		q_2 = (rem_b >= {1'b0, divisor});
		rem_2 = q_2 ? (rem_b[WIDTH-1:0] - divisor) : rem_b[WIDTH-1:0];
	end

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= MD_IDLE;
			step <= '0;
			result_o <= '0;
		end else if (start_i) begin
			state <= MD_MUL;
			step <= '0;
		end else begin
			case (state)
				MD_MUL, MD_DIV: begin
					step <= step + 1'b1;
					if (step == STEP_LAST) begin
						step <= '0;
						state <= (state == MD_MUL) ? MD_DIV : MD_DONE;
					end
				end
				MD_DONE: begin
					// Quotient truncated to the operand width
					result_o <= acc[WIDTH-1:0];
					state <= MD_IDLE;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start_i) begin
			acc <= '0;
			mcand <= {{WIDTH{1'b0}}, mul1_i};
			mplier <= mul2_i;
			divisor <= div_i;
			rem <= '0;
		end else if (state == MD_MUL) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end else if (state == MD_DIV) begin
			acc <= {acc[2*WIDTH-3:0], q_1, q_2};
			rem <= rem_2;
		end
	end

	a_div_nonzero: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		start_i |-> (div_i != '0)
	);

endmodule

/* design/hps_cmd_regs.sv */
// HPS command decoder and settings registers
`include "scaler_consts.svh"

module hps_cmd_regs (
	input  logic                      clk_sys,
	input  logic                      rst_n_i,
	input  logic                      io_uio_i,
	input  logic                      io_strobe_i,
	input  logic [`SCALER_IO_W-1:0]   io_din_i,
	input  video_pkg::ar_resolved_t   ar_resolved_i,
	output video_pkg::frame_size_t    mode_size_o,
	output video_pkg::scale_ctrl_t    scale_ctrl_o,
	output video_pkg::ar_custom_t     ar_custom_o,
	output logic [`SCALER_IO_W-1:0]   io_dout_o
);
	import hps_cmd_pkg::*;

	localparam int PAD_W = `SCALER_IO_W - `SCALER_DIM_W - 1;

	cmd_state_e state;
	cmd_op_e    opcode;
	logic [3:0] arg_cnt;

	//////////////////////////////////////////////////////////////////////
	// Decoder and register file
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= CMD_IDLE;
			opcode <= cmd_op_e'(8'h00);
			arg_cnt <= '0;
			mode_size_o.width <= `SCALER_DEF_WIDTH;
			mode_size_o.height <= `SCALER_DEF_HEIGHT;
			scale_ctrl_o <= '0;
			ar_custom_o <= '0;
			io_dout_o <= '0;
		end else if (!io_uio_i) begin
			// Frame closed, wait for next opcode
			state <= CMD_IDLE;
			io_dout_o <= '0;
		end else if (io_strobe_i) begin
			io_dout_o <= '0;
			if (state == CMD_IDLE) begin
				state <= CMD_ARGS;
				opcode <= cmd_op_e'(io_din_i[7:0]);
				arg_cnt <= '0;
				// Mode-set acknowledge
				if (io_din_i[7:0] == OP_VIDEO_MODE) begin
					io_dout_o <= `SCALER_IO_W'(3);
				end
			end else begin
				// Counter sticks at the top, later words are ignored
				if (arg_cnt != 4'hF) begin
					arg_cnt <= arg_cnt + 4'd1;
				end
				case (opcode)
					OP_VIDEO_MODE: begin
						if (arg_cnt == 4'd0) begin
							mode_size_o.width <= io_din_i[`SCALER_DIM_W-1:0];
							scale_ctrl_o.pix_rep <= io_din_i[15];
						end
						// Words 1..3 are porch and sync, unused here
						if (arg_cnt == 4'd4) begin
							mode_size_o.height <= io_din_i[`SCALER_DIM_W-1:0];
						end
					end
					OP_VSET: begin
						if (arg_cnt == 4'd0) begin
							scale_ctrl_o.vset <= io_din_i[`SCALER_DIM_W-1:0];
						end
					end
					OP_HSET: begin
						if (arg_cnt == 4'd0) begin
							scale_ctrl_o.hset <= io_din_i[`SCALER_DIM_W-1:0];
							scale_ctrl_o.free_scale <= io_din_i[15];
						end
					end
					OP_AR_CUSTOM: begin
						case (arg_cnt)
							4'd0: ar_custom_o.custom1.x <= io_din_i[`SCALER_AR_W-1:0];
							4'd1: ar_custom_o.custom1.y <= io_din_i[`SCALER_AR_W-1:0];
							4'd2: ar_custom_o.custom2.x <= io_din_i[`SCALER_AR_W-1:0];
							4'd3: ar_custom_o.custom2.y <= io_din_i[`SCALER_AR_W-1:0];
							default: ;
						endcase
					end
					OP_STATUS: begin
						// Resolved aspect readback
						if (arg_cnt == 4'd0) begin
							io_dout_o <= {{PAD_W{1'b0}}, ar_resolved_i.arxy, ar_resolved_i.arx};
						end
						if (arg_cnt == 4'd1) begin
							io_dout_o <= {{PAD_W{1'b0}}, ar_resolved_i.arxy, ar_resolved_i.ary};
						end
					end
					default: ;
				endcase
			end
		end
	end

	// Readback must clear as soon as the host drops the frame
	a_dout_clear: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		!io_uio_i |=> (io_dout_o == '0)
	);

endmodule

/* design/aspect_window.sv */
// Aspect ratio window calculator
`include "scaler_consts.svh"

module aspect_window (
	input  logic                      clk_sys,
	input  logic                      rst_n_i,
	input  video_pkg::frame_size_t    mode_size_i,
	input  video_pkg::scale_ctrl_t    scale_ctrl_i,
	input  video_pkg::ar_custom_t     ar_custom_i,
	input  video_pkg::ar_pair_t       core_ar_i,
	output video_pkg::ar_resolved_t   ar_resolved_o,
	output video_pkg::window_t        window_o,
	output video_pkg::frame_size_t    scaled_size_o
);
	import video_pkg::*;

	typedef enum logic [2:0] {
		AW_SELECT,
		AW_START_W,
		AW_WAIT_W,
		AW_START_H,
		AW_WAIT_H,
		AW_CLIP,
		AW_WINDOW
	} aw_state_e;

	aw_state_e state;
	ar_pair_t sel_pair;
	dim_t width_sel, height_sel;
	dim_t calc_x, calc_y;
	dim_t wcalc, hcalc;
	dim_t video_w, video_h;
	dim_t h_off, v_off;
	logic md_start, md_busy;
	dim_t md_mul1, md_mul2, md_div, md_result;

	always_comb begin
		width_sel = (scale_ctrl_i.hset != '0 && scale_ctrl_i.hset < mode_size_i.width) ?
			scale_ctrl_i.hset : mode_size_i.width;
		height_sel = (scale_ctrl_i.vset != '0 && scale_ctrl_i.vset < mode_size_i.height) ?
			scale_ctrl_i.vset : mode_size_i.height;
		// Core y of zero picks a custom ratio by index
		sel_pair = core_ar_i;
		if (core_ar_i.y == '0) begin
			case (core_ar_i.x)
				`SCALER_AR_W'(1): sel_pair = ar_custom_i.custom1;
				`SCALER_AR_W'(2): sel_pair = ar_custom_i.custom2;
				default: sel_pair = '0;
			endcase
		end
		h_off = (mode_size_i.width - video_w) >> 1;
		v_off = (mode_size_i.height - video_h) >> 1;
	end

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			scaled_size_o <= '0;
			ar_resolved_o <= '0;
		end else begin
			scaled_size_o.width <= width_sel << scale_ctrl_i.pix_rep;
			scaled_size_o.height <= height_sel;
			ar_resolved_o.arxy <= sel_pair.x[`SCALER_AR_W-1] | sel_pair.y[`SCALER_AR_W-1];
			ar_resolved_o.arx <= sel_pair.x[`SCALER_DIM_W-1:0];
			ar_resolved_o.ary <= sel_pair.y[`SCALER_DIM_W-1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Window sequencer, runs continuously
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= AW_SELECT;
			md_start <= 1'b0;
			md_mul1 <= '0;
			md_mul2 <= '0;
			md_div <= '0;
			calc_x <= '0;
			calc_y <= '0;
			wcalc <= '0;
			hcalc <= '0;
			video_w <= '0;
			video_h <= '0;
			window_o <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				AW_SELECT: begin
					if (scale_ctrl_i.free_scale || ar_resolved_o.arx == '0 ||
						ar_resolved_o.ary == '0) begin
						wcalc <= scaled_size_o.width;
						hcalc <= scaled_size_o.height;
						state <= AW_CLIP;
					end else if (ar_resolved_o.arxy) begin
						// Absolute picture size
						wcalc <= ar_resolved_o.arx;
						hcalc <= ar_resolved_o.ary;
						state <= AW_CLIP;
					end else begin
						// Ratio held for both divides of this pass
						calc_x <= ar_resolved_o.arx;
						calc_y <= ar_resolved_o.ary;
						state <= AW_START_W;
					end
				end
				AW_START_W: begin
					md_mul1 <= scaled_size_o.height;
					md_mul2 <= calc_x;
					md_div <= calc_y;
					md_start <= 1'b1;
					state <= AW_WAIT_W;
				end
				AW_WAIT_W: begin
					if (!md_start && !md_busy) begin
						wcalc <= md_result;
						state <= AW_START_H;
					end
				end
				AW_START_H: begin
					md_mul1 <= scaled_size_o.width;
					md_mul2 <= calc_y;
					md_div <= calc_x;
					md_start <= 1'b1;
					state <= AW_WAIT_H;
				end
				AW_WAIT_H: begin
					if (!md_start && !md_busy) begin
						hcalc <= md_result;
						state <= AW_CLIP;
					end
				end
				AW_CLIP: begin
					video_w <= ((wcalc > scaled_size_o.width) ? scaled_size_o.width : wcalc) >>
						scale_ctrl_i.pix_rep;
					video_h <= (hcalc > scaled_size_o.height) ? scaled_size_o.height : hcalc;
					state <= AW_WINDOW;
				end
				AW_WINDOW: begin
					// Centre the picture inside the output mode
					window_o.hmin <= h_off;
					window_o.hmax <= h_off + video_w - 1'b1;
					window_o.vmin <= v_off;
					window_o.vmax <= v_off + video_h - 1'b1;
					state <= AW_SELECT;
				end
				default: state <= AW_SELECT;
			endcase
		end
	end

	umuldiv #(
		.WIDTH(`SCALER_DIM_W)
	) u_muldiv (
		.clk_sys  (clk_sys),
		.rst_n_i  (rst_n_i),
		.start_i  (md_start),
		.mul1_i   (md_mul1),
		.mul2_i   (md_mul2),
		.div_i    (md_div),
		.busy_o   (md_busy),
		.result_o (md_result)
	);

	a_no_start_busy: assert property (
		@(posedge clk_sys) disable iff (!rst_n_i)
		md_busy |-> !md_start
	);

endmodule

/* design/scaler_ctrl_top.sv */
// Scaler control top level
`include "scaler_consts.svh"

module scaler_ctrl_top (
	input  logic                      clk_sys,
	input  logic                      rst_n_i,
	input  logic                      io_uio_i,
	input  logic                      io_strobe_i,
	input  logic [`SCALER_IO_W-1:0]   io_din_i,
	input  video_pkg::ar_pair_t       core_ar_i,
	output logic [`SCALER_IO_W-1:0]   io_dout_o,
	output video_pkg::window_t        window_o,
	output video_pkg::frame_size_t    scaled_size_o
);
	import video_pkg::*;

	frame_size_t  mode_size;
	scale_ctrl_t  scale_ctrl;
	ar_custom_t   ar_custom;
	ar_resolved_t ar_resolved;

	// Host command side
	hps_cmd_regs u_cmd_regs (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.io_uio_i      (io_uio_i),
		.io_strobe_i   (io_strobe_i),
		.io_din_i      (io_din_i),
		.ar_resolved_i (ar_resolved),
		.mode_size_o   (mode_size),
		.scale_ctrl_o  (scale_ctrl),
		.ar_custom_o   (ar_custom),
		.io_dout_o     (io_dout_o)
	);

	// Picture window
	aspect_window u_aspect (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.mode_size_i   (mode_size),
		.scale_ctrl_i  (scale_ctrl),
		.ar_custom_i   (ar_custom),
		.core_ar_i     (core_ar_i),
		.ar_resolved_o (ar_resolved),
		.window_o      (window_o),
		.scaled_size_o (scaled_size_o)
	);

endmodule

/* verification/scaler_ctrl_tb.sv */
// Scaler control testbench
`include "scaler_consts.svh"

module scaler_ctrl_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import video_pkg::*;

	localparam string TRACE_FILE = "verification/scaler_trace.txt";
	localparam int SETTLE_CYCLES = 300;
	localparam int CYCLES_PER_LINE = 400;

	typedef logic [8*24-1:0] name_t;

	logic clk_sys;
	logic rst_n_i;
	logic io_uio_i;
	logic io_strobe_i;
	logic [`SCALER_IO_W-1:0] io_din_i;
	ar_pair_t core_ar_i;
	logic [`SCALER_IO_W-1:0] io_dout_o;
	window_t window_o;
	frame_size_t scaled_size_o;
	int trace_lines;

	scaler_ctrl_top UUT (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.io_uio_i      (io_uio_i),
		.io_strobe_i   (io_strobe_i),
		.io_din_i      (io_din_i),
		.core_ar_i     (core_ar_i),
		.io_dout_o     (io_dout_o),
		.window_o      (window_o),
		.scaled_size_o (scaled_size_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_word(input name_t name, input logic [`SCALER_IO_W-1:0] exp,
		input logic [`SCALER_IO_W-1:0] act);
		if (act !== exp) begin
			$display("CHECK FAILED %0s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_window(input name_t name, input window_t exp, input window_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %0s: expected %0d,%0d,%0d,%0d, actual %0d,%0d,%0d,%0d",
				name, exp.hmin, exp.hmax, exp.vmin, exp.vmax,
				act.hmin, act.hmax, act.vmin, act.vmax);
			stop_run();
		end
	endtask

	task automatic check_size(input name_t name, input frame_size_t exp,
		input frame_size_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %0s: expected %0dx%0d, actual %0dx%0d",
				name, exp.width, exp.height, act.width, act.height);
			stop_run();
		end
	endtask

	task automatic report_bad_record(input name_t name);
		$display("Trace record %0s is missing a field or has a bad value", name);
		stop_run();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Bus driver
	//////////////////////////////////////////////////////////////////////

	// One strobe per word with readback valid at the next falling edge
	task automatic send_word(input logic [`SCALER_IO_W-1:0] word);
		@(negedge clk_sys);
		io_uio_i = 1'b1;
		io_strobe_i = 1'b1;
		io_din_i = word;
		@(negedge clk_sys);
		io_strobe_i = 1'b0;
	endtask

	task automatic close_frame(input name_t name);
		@(negedge clk_sys);
		io_uio_i = 1'b0;
		io_din_i = '0;
		@(negedge clk_sys);
		check_word(name, '0, io_dout_o);
	endtask

	task automatic run_command(input int fd, input name_t name, input logic with_readback);
		int count;
		int code;
		int i;
		logic [`SCALER_IO_W-1:0] word;
		logic [`SCALER_IO_W-1:0] exp;
		code = $fscanf(fd, "%d", count);
		if (code != 1 || count < 1) begin
			report_bad_record(name);
		end
		for (i = 0; i < count; i++) begin
			code = $fscanf(fd, "%h", word);
			if (code != 1) begin
				report_bad_record(name);
			end
			if (with_readback) begin
				code = $fscanf(fd, "%h", exp);
				if (code != 1) begin
					report_bad_record(name);
				end
			end
			send_word(word);
			if (with_readback) begin
				check_word(name, exp, io_dout_o);
			end
		end
		close_frame(name);
	endtask

	task automatic set_core_aspect(input int fd, input name_t name);
		logic [`SCALER_AR_W-1:0] x;
		logic [`SCALER_AR_W-1:0] y;
		if ($fscanf(fd, "%h %h", x, y) != 2) begin
			report_bad_record(name);
		end
		@(negedge clk_sys);
		core_ar_i.x = x;
		core_ar_i.y = y;
	endtask

	// Wait out several window passes before comparing
	task automatic settle_and_check(input int fd, input name_t name);
		int hmin, hmax, vmin, vmax, width, height;
		int code;
		window_t exp_win;
		frame_size_t exp_size;
		code = $fscanf(fd, "%d %d %d %d %d %d",
			hmin, hmax, vmin, vmax, width, height);
		if (code != 6) begin
			report_bad_record(name);
		end
		exp_win.hmin = hmin[`SCALER_DIM_W-1:0];
		exp_win.hmax = hmax[`SCALER_DIM_W-1:0];
		exp_win.vmin = vmin[`SCALER_DIM_W-1:0];
		exp_win.vmax = vmax[`SCALER_DIM_W-1:0];
		exp_size.width = width[`SCALER_DIM_W-1:0];
		exp_size.height = height[`SCALER_DIM_W-1:0];
		repeat (SETTLE_CYCLES) @(negedge clk_sys);
		check_window(name, exp_win, window_o);
		check_size(name, exp_size, scaled_size_o);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Trace reader
	//////////////////////////////////////////////////////////////////////

	initial begin
		int fd;
		int code;
		int lines;
		logic [7:0] rtype;
		name_t name;
		logic [8*128-1:0] line;
		rst_n_i = 1'b0;
		io_uio_i = 1'b0;
		io_strobe_i = 1'b0;
		io_din_i = '0;
		core_ar_i = '0;
		trace_lines = 0;
		lines = 0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open trace file %0s", TRACE_FILE);
			stop_run();
		end
		// Line count sets the watchdog limit
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code > 0) begin
				lines++;
			end
		end
		$fclose(fd);
		trace_lines = lines;
		fd = $fopen(TRACE_FILE, "r");
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n_i = 1'b1;
		while ($fscanf(fd, "%s", rtype) == 1) begin
			if (rtype == "#") begin
				code = $fgets(line, fd);
			end else begin
				if ($fscanf(fd, "%s", name) != 1) begin
					$display("Trace record of type %s has no name", rtype);
					stop_run();
				end
				case (rtype)
					"C": run_command(fd, name, 1'b0);
					"R": run_command(fd, name, 1'b1);
					"A": set_core_aspect(fd, name);
					"K": settle_and_check(fd, name);
					default: begin
						$display("Unknown record type %s in trace", rtype);
						stop_run();
					end
				endcase
			end
		end
		$fclose(fd);
		$display("All tests passed");
		$finish;
	end

	// Watchdog
	initial begin
		wait (trace_lines != 0);
		repeat (trace_lines * CYCLES_PER_LINE) @(posedge clk_sys);
		$display("Timeout after %0d cycles, trace did not finish",
			trace_lines * CYCLES_PER_LINE);
		stop_run();
	end

endmodule

/* files.f */
+incdir+design
design/video_pkg.sv
design/hps_cmd_pkg.sv
design/umuldiv.sv
design/hps_cmd_regs.sv
design/aspect_window.sv
design/scaler_ctrl_top.sv
verification/scaler_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scaler control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module scaler_ctrl_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vscaler_ctrl_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" "$LOG"; then
	exit 0
fi
exit 1

/* verification/scaler_trace.txt */
# type name fields. C and R: word count, then words in hex (R adds expected readback per word)
# A: core aspect x y in hex. K: hmin hmax vmin vmax width height in decimal after settling
K reset_full 0 1919 0 1079 1920 1080
R mode_720 6 0020 0003 0500 0000 0000 0000 0000 0000 0000 0000 02D0 0000
K mode_720_win 0 1279 0 719 1280 720
R mode_1080 6 0020 0003 0780 0000 0000 0000 0000 0000 0000 0000 0438 0000
K mode_1080_win 0 1919 0 1079 1920 1080
A ar_4_3 0004 0003
K ar_4_3_win 240 1679 0 1079 1920 1080
C free_on 2 0037 8000
K free_scale_win 0 1919 0 1079 1920 1080
C free_off 2 0037 0000
K ar_4_3_again 240 1679 0 1079 1920 1080
C vset_540 2 0027 021C
K vset_win 600 1319 270 809 1920 540
C hset_960 2 0037 03C0
K hset_win 600 1319 270 809 960 540
A ar_none 0000 0000
K hset_full_win 480 1439 270 809 960 540
C vset_clear 2 0027 0000
C hset_clear 2 0037 0000
C ar_custom 5 003A 0004 0003 0015 0009
A pick_custom2 0002 0000
K custom2_win 0 1919 129 950 1920 1080
R status_custom2 3 0040 0000 0000 0015 0000 0009
A ar_abs_fit 1500 02D0
K abs_fit_win 320 1599 180 899 1920 1080
A ar_abs_clip 1FA0 0200
K abs_clip_win 0 1919 284 795 1920 1080
R status_abs 3 0040 0000 0000 1FA0 0000 1200
R ack_drop 1 0020 0003
